// File: source/noc_topo_pkg.sv
/*
  Mesh shape, default node location and port numbering for one router node.
  Every mesh size must be 2 or more so no coordinate width collapses to zero.
  Port order follows the c,n,e,s,w,d,u request vector, core first.
*/
package noc_topo_pkg;

  // Mesh size
  // ------------------------------------------------------------------
  localparam int X_NODES = 4;            // Node columns
  localparam int Y_NODES = 4;            // Node rows
  localparam int Z_NODES = 2;            // Node layers

  localparam int X_W = $clog2(X_NODES);  // 2 bits
  localparam int Y_W = $clog2(Y_NODES);  // 2 bits
  localparam int Z_W = $clog2(Z_NODES);  // 1 bit

  // Default node location, overridden per node in a full mesh
  localparam int X_LOC = 1;
  localparam int Y_LOC = 2;
  localparam int Z_LOC = 0;

  // Ports
  // ------------------------------------------------------------------
  localparam int N_PORTS    = 7;
  localparam int PORT_IDX_W = $clog2(N_PORTS);  // Wide enough for 0..6

  localparam int PORT_C = 0;  // Local core
  localparam int PORT_N = 1;  // Y up
  localparam int PORT_E = 2;  // X up
  localparam int PORT_S = 3;  // Y down
  localparam int PORT_W = 4;  // X down
  localparam int PORT_D = 5;  // Z down
  localparam int PORT_U = 6;  // Z up

endpackage

// File: source/noc_flit_pkg.sv
/*
  Flit layout, queue depth and the per-port mask.
  A flit is a whole packet: destination coordinates and a payload.
  Depth must be a power of two of at least 2.
*/
package noc_flit_pkg;

  localparam int PAYLOAD_W = 16;  // Payload bits per flit

  // Flit layout, destination first, 21 bits in all
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [noc_topo_pkg::X_W-1:0] x_dest;   // Destination column
    logic [noc_topo_pkg::Y_W-1:0] y_dest;   // Destination row
    logic [noc_topo_pkg::Z_W-1:0] z_dest;   // Destination layer
    logic [PAYLOAD_W-1:0]         payload;  // User data
  } flit_t;

  // One bit per port, bit 0 is core and bit 6 is up
  typedef logic [0:noc_topo_pkg::N_PORTS-1] port_mask_t;

  // Input queue
  // ------------------------------------------------------------------
  localparam int QUEUE_DEPTH = 4;                     // Flits per input
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);   // Read/write pointer width

endpackage

// File: source/noc_route_calc.sv
/*
  Oblivious dimension-ordered routing for a 3D mesh, X then Y then Z.
  No torus wraparound and no adaptive choice.
  Output is a one-hot request, all zero when the head is not valid.
*/
`timescale 1ns/1ns

module noc_route_calc #(
  parameter int X_LOC = noc_topo_pkg::X_LOC,  // This node's column
  parameter int Y_LOC = noc_topo_pkg::Y_LOC,  // This node's row
  parameter int Z_LOC = noc_topo_pkg::Z_LOC   // This node's layer
) (
  input  logic [noc_topo_pkg::X_W-1:0] i_x_dest,     // Head flit destination, X
  input  logic [noc_topo_pkg::Y_W-1:0] i_y_dest,     // Head flit destination, Y
  input  logic [noc_topo_pkg::Z_W-1:0] i_z_dest,     // Head flit destination, Z
  input  logic                         i_val,        // Head flit present
  output noc_flit_pkg::port_mask_t     o_output_req  // One-hot output port request
);

  import noc_topo_pkg::*;

  // Route decision
  // ------------------------------------------------------------------
  always_comb begin
    o_output_req = '0;
    if (i_val) begin
      if (i_x_dest != X_LOC) begin
        // Resolve X before anything else
        if (i_x_dest > X_LOC) o_output_req[PORT_E] = 1'b1;
        else                  o_output_req[PORT_W] = 1'b1;
      end else if (i_y_dest != Y_LOC) begin
        // X done, now Y
        if (i_y_dest > Y_LOC) o_output_req[PORT_N] = 1'b1;
        else                  o_output_req[PORT_S] = 1'b1;
      end else if (i_z_dest != Z_LOC) begin
        // Same column and row, change layer
        if (i_z_dest > Z_LOC) o_output_req[PORT_U] = 1'b1;
        else                  o_output_req[PORT_D] = 1'b1;
      end else begin
        o_output_req[PORT_C] = 1'b1;  // Arrived, hand to the core
      end
    end
  end

endmodule

// File: source/noc_input_queue.sv
/*
  Small circular flit queue for one router input.
  A write while full is dropped, so the sender must watch o_full.
  A pop while empty is ignored. Head flit is valid only with o_head_valid.
*/
`timescale 1ns/1ns

module noc_input_queue (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_wr,          // Write strobe from upstream
  input  noc_flit_pkg::flit_t i_wr_flit,     // Flit to store
  input  logic                i_pop,         // Head leaves this cycle
  output noc_flit_pkg::flit_t o_head_flit,   // Oldest stored flit
  output logic                o_head_valid,  // Queue not empty
  output logic                o_full         // No room for another write
);

  import noc_flit_pkg::*;

  flit_t                  mem [QUEUE_DEPTH];  // Flit storage
  logic [QUEUE_PTR_W-1:0] wr_ptr;             // Next free slot
  logic [QUEUE_PTR_W-1:0] rd_ptr;             // Oldest flit
  logic [QUEUE_PTR_W:0]   count;              // Occupancy, 0..QUEUE_DEPTH
  logic                   do_wr;
  logic                   do_pop;

  // Wrap a pointer at the last slot
  function automatic logic [QUEUE_PTR_W-1:0] ptr_next(input logic [QUEUE_PTR_W-1:0] ptr);
    return (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_wr  = i_wr && !o_full;         // Drop writes when full
  assign do_pop = i_pop && o_head_valid;   // Ignore pops when empty

  // Storage
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (do_wr) mem[wr_ptr] <= i_wr_flit;
  end

  // Pointers and occupancy
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)  wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      case ({do_wr, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither, level unchanged
      endcase
    end
  end

  assign o_head_flit  = mem[rd_ptr];
  assign o_head_valid = (count != '0);
  assign o_full       = (count == QUEUE_DEPTH);

endmodule

// File: source/noc_output_port.sv
/*
  One router output: round-robin choice among the seven inputs.
  Grant is combinational and pops the winner's queue in the same cycle.
  Flit and valid leave one cycle later. No downstream back-pressure.
*/
`timescale 1ns/1ns

module noc_output_port (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  noc_flit_pkg::port_mask_t i_req,                           // One bit per input
  input  noc_flit_pkg::flit_t      i_flits [noc_topo_pkg::N_PORTS], // Head flit per input
  output noc_flit_pkg::port_mask_t o_grant,                         // One-hot winner
  output logic                     o_out_valid,                     // One-cycle pulse
  output noc_flit_pkg::flit_t      o_out_flit                       // Registered flit
);

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  logic [PORT_IDX_W-1:0] rr_ptr;  // Highest priority input this cycle
  logic [PORT_IDX_W-1:0] winner;  // Chosen input
  logic                  found;   // Some input requested
  int                    cand;    // Input under test in the scan

  // Arbitration
  // ------------------------------------------------------------------
  always_comb begin
    found   = 1'b0;
    winner  = rr_ptr;
    cand    = 0;
    o_grant = '0;
    // Scan from the pointer upwards, wrapping past the last input
    for (int i = 0; i < N_PORTS; i++) begin
      cand = int'(rr_ptr) + i;
      if (cand >= N_PORTS) cand = cand - N_PORTS;
      if (!found && i_req[cand]) begin
        found  = 1'b1;
        winner = PORT_IDX_W'(cand);
      end
    end
    if (found) o_grant[winner] = 1'b1;
  end

  // Valid pulse and pointer
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_out_valid <= 1'b0;
      rr_ptr      <= '0;
    end else begin
      o_out_valid <= found;
      if (found) begin
        // Winner goes to the back of the line
        if (winner == PORT_IDX_W'(N_PORTS - 1)) rr_ptr <= '0;
        else                                    rr_ptr <= winner + 1'b1;
      end
    end
  end

  // Output flit, held between deliveries
  always_ff @(posedge i_clk) begin
    if (found) o_out_flit <= i_flits[winner];
  end

endmodule

// File: source/noc_router.sv
/*
  One node of a 3D mesh NoC with seven ports, c,n,e,s,w,d,u.
  Single-flit packets, dimension-ordered routing, no virtual channels.
  Senders must hold off while o_in_full is high. Outputs are always accepted.
*/
`timescale 1ns/1ns

module noc_router (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  noc_flit_pkg::port_mask_t i_in_valid,                         // Write strobe per input
  input  noc_flit_pkg::flit_t      i_in_flit   [noc_topo_pkg::N_PORTS], // Flit per input
  output noc_flit_pkg::port_mask_t o_in_full,                          // Queue full per input
  output noc_flit_pkg::port_mask_t o_out_valid,                        // Delivery per output
  output noc_flit_pkg::flit_t      o_out_flit  [noc_topo_pkg::N_PORTS]  // Flit per output
);

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  flit_t      head_flit    [N_PORTS];  // Queue heads, indexed by input
  port_mask_t head_valid;              // Queue not empty, by input
  port_mask_t req_by_in    [N_PORTS];  // Route request, [input][output]
  port_mask_t req_by_out   [N_PORTS];  // Same requests, [output][input]
  port_mask_t grant_by_out [N_PORTS];  // Grants, [output][input]
  port_mask_t pop;                     // Pop strobe per input

  // Input side, one queue and one route calculator per port
  // ------------------------------------------------------------------
  for (genvar p = 0; p < N_PORTS; p++) begin : g_in
    noc_input_queue u_queue (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_wr         (i_in_valid[p]),
      .i_wr_flit    (i_in_flit[p]),
      .i_pop        (pop[p]),
      .o_head_flit  (head_flit[p]),
      .o_head_valid (head_valid[p]),
      .o_full       (o_in_full[p])
    );

    noc_route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC),
      .Z_LOC (Z_LOC)
    ) u_route (
      .i_x_dest     (head_flit[p].x_dest),
      .i_y_dest     (head_flit[p].y_dest),
      .i_z_dest     (head_flit[p].z_dest),
      .i_val        (head_valid[p]),
      .o_output_req (req_by_in[p])
    );
  end

  // Requests regrouped so each output sees one bit from every input
  always_comb begin
    for (int q = 0; q < N_PORTS; q++) begin
      for (int p = 0; p < N_PORTS; p++) begin
        req_by_out[q][p] = req_by_in[p][q];
      end
    end
  end

  // At most one output grants a given input, OR is enough
  always_comb begin
    pop = '0;
    for (int p = 0; p < N_PORTS; p++) begin
      for (int q = 0; q < N_PORTS; q++) begin
        pop[p] = pop[p] | grant_by_out[q][p];
      end
    end
  end

  // Output side, one arbiter and register per port
  // ------------------------------------------------------------------
  for (genvar q = 0; q < N_PORTS; q++) begin : g_out
    noc_output_port u_out (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_req       (req_by_out[q]),
      .i_flits     (head_flit),
      .o_grant     (grant_by_out[q]),
      .o_out_valid (o_out_valid[q]),
      .o_out_flit  (o_out_flit[q])
    );
  end

endmodule

// File: sim/noc_router_assert.sv
/*
  Bound checks on route requests, grants and upstream writes of the router.
  Requests must be one-hot or zero, each input is granted by at most one output,
  and no write may hit a full queue.
*/
`timescale 1ns/1ns

module noc_router_assert (
  input logic                     i_clk,
  input logic                     i_rst,
  input noc_flit_pkg::port_mask_t i_req_by_in    [noc_topo_pkg::N_PORTS],  // [input][output]
  input noc_flit_pkg::port_mask_t i_grant_by_out [noc_topo_pkg::N_PORTS],  // [output][input]
  input noc_flit_pkg::port_mask_t i_in_valid,
  input noc_flit_pkg::port_mask_t i_in_full
);

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  port_mask_t grant_by_in [N_PORTS];  // Grants regrouped as [input][output]

  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      for (int q = 0; q < N_PORTS; q++) begin
        grant_by_in[p][q] = i_grant_by_out[q][p];
      end
    end
  end

  // Per port checks
  // ------------------------------------------------------------------
  for (genvar p = 0; p < N_PORTS; p++) begin : g_port
    a_req_onehot0: assert property (@(posedge i_clk) disable iff (i_rst)
      $onehot0(i_req_by_in[p]))
      else $error("Route request of input %0d is not one-hot", p);

    // Two grants to one input would pop a single head twice
    a_grant_onehot0: assert property (@(posedge i_clk) disable iff (i_rst)
      $onehot0(grant_by_in[p]))
      else $error("Input %0d granted by more than one output", p);

    // A write into a full queue would be dropped
    a_no_write_full: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_in_valid[p] && i_in_full[p]))
      else $error("Input %0d written while full", p);
  end

endmodule

bind noc_router noc_router_assert u_assert (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_req_by_in    (req_by_in),
  .i_grant_by_out (grant_by_out),
  .i_in_valid     (i_in_valid),
  .i_in_full      (o_in_full)
);

// File: sim/noc_router_tb.sv
/*
  Testbench for the router node at (1,2,0), with random traffic from a fixed seed.
  Deliveries are checked against reference queues kept per input and output.
  The last stimulus phase sends all flits east, to check round-robin fairness.
*/
`timescale 1ns/1ns

module noc_router_tb;

  import noc_topo_pkg::*;
  import noc_flit_pkg::*;

  localparam int RST_CYCLES     = 2;
  localparam int RAND_CYCLES    = 1500;  // Mixed destinations
  localparam int STIM_CYCLES    = 2000;  // Random phase plus saturation phase
  localparam int WARMUP         = 50;    // Queues fill up before the fairness checks
  localparam int DRAIN_CYCLES   = 200;
  localparam int TAIL_CYCLES    = 10;    // Idle time that catches late duplicates
  localparam int TIMEOUT_CYCLES = RST_CYCLES + STIM_CYCLES + DRAIN_CYCLES + TAIL_CYCLES;
  localparam int SRC_W          = 3;                  // Source index in payload MSBs
  localparam int SEQ_W          = PAYLOAD_W - SRC_W;  // Running sequence number
  localparam int SAT_PORT       = PORT_E;             // Column 3 lies east of column 1

  logic       clk;
  logic       rst;
  port_mask_t in_valid;
  flit_t      in_flit  [N_PORTS];
  port_mask_t in_full;
  port_mask_t out_valid;
  flit_t      out_flit [N_PORTS];

  flit_t model_q [N_PORTS][N_PORTS][$];  // Expected flits by input and output
  int    seq     [N_PORTS];              // Next sequence number per input
  int    win_cnt [N_PORTS][N_PORTS];     // [a][b] wins of b since a last won
  bit    sat_check;                      // Fairness window open
  int    value_errors;
  int    other_errors;
  int    cycles;

  noc_router UUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_in_valid  (in_valid),
    .i_in_flit   (in_flit),
    .o_in_full   (in_full),
    .o_out_valid (out_valid),
    .o_out_flit  (out_flit)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Reference model
  // ------------------------------------------------------------------
  // X first, then Y, then Z, core once all three match
  function automatic int route_port(input flit_t f);
    if (int'(f.x_dest) > X_LOC) return PORT_E;
    if (int'(f.x_dest) < X_LOC) return PORT_W;
    if (int'(f.y_dest) > Y_LOC) return PORT_N;
    if (int'(f.y_dest) < Y_LOC) return PORT_S;
    if (int'(f.z_dest) > Z_LOC) return PORT_U;
    if (int'(f.z_dest) < Z_LOC) return PORT_D;
    return PORT_C;
  endfunction

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int p = 0; p < N_PORTS; p++) begin
      for (int q = 0; q < N_PORTS; q++) n += model_q[p][q].size();
    end
    return n;
  endfunction

  // Input a still has flits for the saturated output and nothing else ahead
  function automatic bit waiting_on_sat(input int a);
    bit w;
    w = (model_q[a][SAT_PORT].size() != 0);
    for (int q = 0; q < N_PORTS; q++) begin
      if (q != SAT_PORT && model_q[a][q].size() != 0) w = 1'b0;
    end
    return w;
  endfunction

  // Compare tasks
  // ------------------------------------------------------------------
  task automatic compare_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_mask(input string name, input port_mask_t exp, input port_mask_t act);
    if (act !== exp) begin
      value_errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Each input with room sends with probability one half
  task automatic drive_inputs(input bit saturate);
    flit_t f;
    for (int p = 0; p < N_PORTS; p++) begin
      in_valid[p] = 1'b0;
      if (!in_full[p] && ($urandom % 2) == 1) begin
        if (saturate) begin
          f.x_dest = X_W'(X_NODES - 1);  // One fixed destination for everyone
          f.y_dest = Y_W'(Y_LOC);
          f.z_dest = Z_W'(Z_LOC);
        end else begin
          f.x_dest = X_W'($urandom % X_NODES);
          f.y_dest = Y_W'($urandom % Y_NODES);
          f.z_dest = Z_W'($urandom % Z_NODES);
        end
        f.payload   = {SRC_W'(p), SEQ_W'(seq[p])};
        seq[p]++;
        in_flit[p]  = f;
        in_valid[p] = 1'b1;
        model_q[p][route_port(f)].push_back(f);
      end
    end
  endtask

  // Between two wins of s, each other waiting input wins at most once
  task automatic track_round_robin(input int s);
    for (int b = 0; b < N_PORTS; b++) begin
      if (win_cnt[s][b] > 1) begin
        other_errors++;
        $display("Round-robin broken on output %0d, input %0d won %0d times before input %0d",
                 SAT_PORT, b, win_cnt[s][b], s);
      end
      win_cnt[s][b] = 0;
    end
    for (int a = 0; a < N_PORTS; a++) begin
      if (a != s) win_cnt[a][s]++;
    end
  endtask

  task automatic check_delivery(input int q, input flit_t f);
    int         src;
    port_mask_t exp_m;
    port_mask_t act_m;
    src   = int'(f.payload[PAYLOAD_W-1 -: SRC_W]);
    exp_m = '0;
    act_m = '0;
    exp_m[route_port(f)] = 1'b1;
    act_m[q]             = 1'b1;
    compare_mask("output port", exp_m, act_m);  // Self-addressed flits expect core only
    if (src >= N_PORTS) begin
      other_errors++;
      $display("Flit on output %0d carries an unknown source %0d", q, src);
    end else if (model_q[src][q].size() == 0) begin
      other_errors++;
      $display("Output %0d delivered a flit from input %0d that was never sent", q, src);
    end else begin
      compare_flit("in-order delivery", model_q[src][q].pop_front(), f);
      if (q == SAT_PORT && sat_check) track_round_robin(src);
    end
  endtask

  // Monitor at the falling edge where outputs are stable
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (!rst) begin
      for (int q = 0; q < N_PORTS; q++) begin
        if (out_valid[q]) check_delivery(q, out_flit[q]);
      end
      for (int a = 0; a < N_PORTS; a++) begin
        if (!waiting_on_sat(a)) begin
          for (int b = 0; b < N_PORTS; b++) win_cnt[a][b] = 0;  // Count restarts when idle
        end
      end
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      other_errors++;
      $display("Timeout after %0d cycles with %0d flits still undelivered",
               cycles, pending_flits());
      $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
      $display("Something failed");
      $finish;
    end
  end

  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    void'($urandom(62));
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = '0;
    sat_check    = 1'b0;
    value_errors = 0;
    other_errors = 0;
    cycles       = 0;
    for (int p = 0; p < N_PORTS; p++) begin
      in_flit[p] = '0;
      seq[p]     = 0;
      for (int b = 0; b < N_PORTS; b++) win_cnt[p][b] = 0;
    end

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    compare_mask("reset out_valid", '0, out_valid);
    compare_mask("reset in_full", '0, in_full);
    rst = 1'b0;

    for (int c = 0; c < STIM_CYCLES; c++) begin
      @(posedge clk);
      #1;
      sat_check = (c >= RAND_CYCLES + WARMUP);
      drive_inputs(c >= RAND_CYCLES);
    end
    @(posedge clk);
    #1;
    in_valid  = '0;
    sat_check = 1'b0;

    // Drain until every reference queue is empty
    while (pending_flits() != 0) @(posedge clk);
    repeat (TAIL_CYCLES) @(posedge clk);
    #1;
    compare_mask("drained in_full", '0, in_full);

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: noc_router.f
source/noc_topo_pkg.sv
source/noc_flit_pkg.sv
source/noc_route_calc.sv
source/noc_input_queue.sv
source/noc_output_port.sv
source/noc_router.sv
sim/noc_router_assert.sv
sim/noc_router_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := noc_router_tb
FILELIST := noc_router.f
OBJ_DIR  := obj_dir
PASS_MSG := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message appears on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
